/* rtl/dsp_types_pkg.sv */
// Q1.11 samples only; constellation levels assume unit peak gain ahead of the loop
`default_nettype none

package dsp_types_pkg;

    // ============================================================
    // Sample and product formats
    // ============================================================
    localparam int data_width    = 12;
    localparam int frac_bits     = 11;
    localparam int product_width = 24;

    typedef logic signed [data_width-1:0]    sample_t;
    typedef logic signed [product_width-1:0] product_t;

    // 16-QAM levels per rail, Q1.11
    localparam sample_t qam_neg3 = -12'sd1943;
    localparam sample_t qam_neg1 = -12'sd648;
    localparam sample_t qam_pos1 = 12'sd648;
    localparam sample_t qam_pos3 = 12'sd1943;

    // Midpoint between inner and outer levels
    localparam sample_t slicer_th = 12'sd1296;

    // Saturation limits
    localparam sample_t sat_pos = 12'sd2047;
    localparam sample_t sat_neg = -12'sd2048;

endpackage

`default_nettype wire

/* rtl/loop_cfg_pkg.sv */
// Gains are fixed shifts; holdoff and gear counts must stay within the 9-bit symbol count
`default_nettype none

package loop_cfg_pkg;

    // NCO phase word and table address
    localparam int nco_w        = 16;
    localparam int phase_byte_w = 8;
    typedef logic [nco_w-1:0] nco_t;

    // ============================================================
    // Loop filter gears
    // ============================================================
    localparam int kp_shift_acq = 5;
    localparam int kp_shift_trk = 3;
    localparam int ki_shift_acq = 4;
    localparam int ki_shift_trk = 12;
    // Omega limit, about an eighth of full scale
    localparam int freq_bound   = 8191;

    // Symbol count thresholds
    typedef logic [8:0] sym_cnt_t;
    localparam sym_cnt_t holdoff_syms    = 9'd30;
    localparam sym_cnt_t gear_syms       = 9'd300;
    localparam sym_cnt_t lock_ready_syms = 9'd100;

    // Lock detector
    localparam int lock_avg_shift = 6;
    localparam int lock_threshold = 150;

    typedef enum logic [1:0] {
        mode_hold    = 2'd0,
        mode_acquire = 2'd1,
        mode_track   = 2'd2
    } loop_mode_t;

endpackage

`default_nettype wire

/* rtl/sincos_lut.sv */
// Purely combinational, 256 phase steps per turn, peak amplitude 2047 (not 2048)
`default_nettype none

module sincos_lut (
    input  wire logic [7:0]             phase_byte,
    output dsp_types_pkg::sample_t      cos_val,
    output dsp_types_pkg::sample_t      sin_val
);

    // ============================================================
    // Quarter-wave table, round(2047*cos(pi*i/128)), i = 0..64
    // ============================================================
    localparam logic [10:0] cos_tab [0:64] = '{
        11'd2047, 11'd2046, 11'd2045, 11'd2041, 11'd2037, 11'd2032, 11'd2025, 11'd2017,
        11'd2008, 11'd1997, 11'd1986, 11'd1973, 11'd1959, 11'd1944, 11'd1927, 11'd1910,
        11'd1891, 11'd1871, 11'd1850, 11'd1828, 11'd1805, 11'd1781, 11'd1756, 11'd1729,
        11'd1702, 11'd1674, 11'd1644, 11'd1614, 11'd1582, 11'd1550, 11'd1517, 11'd1483,
        11'd1447, 11'd1411, 11'd1375, 11'd1337, 11'd1299, 11'd1259, 11'd1219, 11'd1179,
        11'd1137, 11'd1095, 11'd1052, 11'd1009, 11'd965,  11'd920,  11'd875,  11'd830,
        11'd783,  11'd737,  11'd690,  11'd642,  11'd594,  11'd546,  11'd497,  11'd449,
        11'd399,  11'd350,  11'd300,  11'd251,  11'd201,  11'd151,  11'd100,  11'd50,
        11'd0
    };

    logic [1:0]  quad;
    logic [6:0]  idx_fwd;
    logic [6:0]  idx_rev;
    logic [10:0] mag_fwd;
    logic [10:0] mag_rev;
    logic [10:0] cos_mag;
    logic [10:0] sin_mag;
    logic        cos_neg;
    logic        sin_neg;

    // Top two bits pick the quadrant, low six walk the quarter wave
    assign quad    = phase_byte[7:6];
    assign idx_fwd = {1'b0, phase_byte[5:0]};
    assign idx_rev = 7'd64 - idx_fwd;

    assign mag_fwd = cos_tab[idx_fwd];
    assign mag_rev = cos_tab[idx_rev];

    // Odd quadrants swap the forward and reversed lookups
    assign cos_mag = quad[0] ? mag_rev : mag_fwd;
    assign sin_mag = quad[0] ? mag_fwd : mag_rev;

    // Cosine negative in quadrants 1 and 2, sine in 2 and 3
    assign cos_neg = quad[1] ^ quad[0];
    assign sin_neg = quad[1];

    // Magnitude never exceeds 2047, so negation cannot overflow
    assign cos_val = cos_neg ? -dsp_types_pkg::sample_t'({1'b0, cos_mag})
                             : dsp_types_pkg::sample_t'({1'b0, cos_mag});
    assign sin_val = sin_neg ? -dsp_types_pkg::sample_t'({1'b0, sin_mag})
                             : dsp_types_pkg::sample_t'({1'b0, sin_mag});

endmodule

`default_nettype wire

/* rtl/phase_rotator.sv */
// Inputs are sampled only on sym_strobe; sin/cos must be settled in that same cycle
`default_nettype none

module phase_rotator (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire dsp_types_pkg::sample_t sym_i,
    input  wire dsp_types_pkg::sample_t sym_q,
    input  wire logic                   sym_strobe,
    input  wire dsp_types_pkg::sample_t cos_val,
    input  wire dsp_types_pkg::sample_t sin_val,
    output dsp_types_pkg::sample_t      rot_i,
    output dsp_types_pkg::sample_t      rot_q,
    output logic                        rot_valid
);

    import dsp_types_pkg::*;

    // Drop the fraction and saturate unless bits 24:22 all agree
    function automatic sample_t trunc_sat(input logic signed [product_width:0] val);
        logic [2:0] guard;
        guard = val[product_width -: 3];
        if (!guard[2] && guard != 3'b000)
            trunc_sat = sat_pos;
        else if (guard[2] && guard != 3'b111)
            trunc_sat = sat_neg;
        else
            trunc_sat = val[frac_bits+data_width-1 : frac_bits];
    endfunction

    // Four Q2.22 products
    product_t p_ic;
    product_t p_qs;
    product_t p_qc;
    product_t p_is;
    logic signed [product_width:0] sum_i;
    logic signed [product_width:0] sum_q;

    assign p_ic = sym_i * cos_val;
    assign p_qs = sym_q * sin_val;
    assign p_qc = sym_q * cos_val;
    assign p_is = sym_i * sin_val;

    // Conjugate rotation removes the NCO phase
    assign sum_i = (product_width+1)'(p_ic) + (product_width+1)'(p_qs);
    assign sum_q = (product_width+1)'(p_qc) - (product_width+1)'(p_is);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rot_i     <= '0;
            rot_q     <= '0;
            rot_valid <= 1'b0;
        end else begin
            rot_valid <= sym_strobe;
            if (sym_strobe) begin
                rot_i <= trunc_sat(sum_i);
                rot_q <= trunc_sat(sum_q);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/decision_stage.sv */
// phase_err is combinational and only meaningful while rot_valid is high
`default_nettype none

module decision_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire dsp_types_pkg::sample_t rot_i,
    input  wire dsp_types_pkg::sample_t rot_q,
    input  wire logic                   rot_valid,
    output dsp_types_pkg::sample_t      phase_err,
    output dsp_types_pkg::sample_t      demod_i,
    output dsp_types_pkg::sample_t      demod_q,
    output logic                        demod_valid
);

    import dsp_types_pkg::*;

    // Nearest level, boundaries at -th, 0 and +th
    function automatic sample_t qam_slice(input sample_t x);
        if (x < -slicer_th)
            qam_slice = qam_neg3;
        else if (x < 12'sd0)
            qam_slice = qam_neg1;
        else if (x < slicer_th)
            qam_slice = qam_pos1;
        else
            qam_slice = qam_pos3;
    endfunction

    sample_t  i_hat;
    sample_t  q_hat;
    product_t pe_qi;
    product_t pe_iq;
    logic signed [product_width:0] pe_full;

    assign i_hat = qam_slice(rot_i);
    assign q_hat = qam_slice(rot_q);

    // Cross product, positive when the NCO lags the symbol
    assign pe_qi   = rot_q * i_hat;
    assign pe_iq   = rot_i * q_hat;
    assign pe_full = (product_width+1)'(pe_qi) - (product_width+1)'(pe_iq);

    // Bits 23:12 as the loop error
    assign phase_err = pe_full[product_width-1 -: data_width];

    // ============================================================
    // Output register, one cycle behind rot_valid
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            demod_i     <= '0;
            demod_q     <= '0;
            demod_valid <= 1'b0;
        end else begin
            demod_valid <= rot_valid;
            if (rot_valid) begin
                demod_i <= rot_i;
                demod_q <= rot_q;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/loop_filter_nco.sv */
// Frozen in hold mode; omega clamp is symmetric, phase wraps modulo 2^16
`default_nettype none

module loop_filter_nco (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire dsp_types_pkg::sample_t   phase_err,
    input  wire logic                     rot_valid,
    input  wire loop_cfg_pkg::loop_mode_t loop_mode,
    output logic [loop_cfg_pkg::phase_byte_w-1:0] phase_byte
);

    import loop_cfg_pkg::*;

    // Arithmetic shift that rounds toward zero on both signs
    function automatic logic signed [nco_w-1:0] shift_tz(
        input logic signed [nco_w-1:0] x,
        input int                      sh
    );
        if (x < 0)
            shift_tz = -((-x) >>> sh);
        else
            shift_tz = x >>> sh;
    endfunction

    nco_t                    nco_phase;
    logic signed [nco_w-1:0] omega;
    logic signed [nco_w-1:0] omega_next;
    logic signed [nco_w:0]   omega_sum;
    logic signed [nco_w-1:0] err_ext;
    logic signed [nco_w-1:0] kp_term;
    logic signed [nco_w-1:0] ki_term;
    int                      kp_sh;
    int                      ki_sh;

    assign err_ext = nco_w'(phase_err);

    // Gear select, tracking uses strong Kp and a near-frozen Ki
    always_comb begin
        kp_sh = (loop_mode == mode_track) ? kp_shift_trk : kp_shift_acq;
        ki_sh = (loop_mode == mode_track) ? ki_shift_trk : ki_shift_acq;
    end

    assign kp_term   = shift_tz(err_ext, kp_sh);
    assign ki_term   = shift_tz(err_ext, ki_sh);
    assign omega_sum = (nco_w+1)'(omega) + (nco_w+1)'(ki_term);

    // Anti-windup clamp
    always_comb begin
        if (omega_sum > freq_bound)
            omega_next = nco_w'(freq_bound);
        else if (omega_sum < -freq_bound)
            omega_next = -nco_w'(freq_bound);
        else
            omega_next = omega_sum[nco_w-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            omega     <= '0;
            nco_phase <= '0;
        end else if (rot_valid && (loop_mode != mode_hold)) begin
            omega     <= omega_next;
            nco_phase <= nco_phase + nco_t'(omega_next + kp_term);
        end
    end

    // Table address is the top byte
    assign phase_byte = nco_phase[nco_w-1 -: phase_byte_w];

endmodule

`default_nettype wire

/* rtl/loop_sequencer.sv */
// Count saturates at gear_syms; modes only move forward until the next reset
`default_nettype none

module loop_sequencer (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   rot_valid,
    output loop_cfg_pkg::loop_mode_t    loop_mode,
    output logic                        lock_ready
);

    import loop_cfg_pkg::*;

    sym_cnt_t sym_cnt;

    // ============================================================
    // Symbol count, mode FSM and lock holdoff flag
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sym_cnt    <= '0;
            loop_mode  <= mode_hold;
            lock_ready <= 1'b0;
        end else if (rot_valid) begin
            if (sym_cnt != gear_syms)
                sym_cnt <= sym_cnt + 1'b1;
            // Flag rises together with the count reaching 100
            if (sym_cnt == lock_ready_syms - 1'b1)
                lock_ready <= 1'b1;
            case (loop_mode)
                mode_hold: begin
                    if (sym_cnt == holdoff_syms - 1'b1)
                        loop_mode <= mode_acquire;
                end
                mode_acquire: begin
                    if (sym_cnt == gear_syms - 1'b1)
                        loop_mode <= mode_track;
                end
                // Track is terminal, the unused code falls into it
                default: loop_mode <= mode_track;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/lock_detector.sv */
// Average starts at full scale, so lock needs many low-error symbols after reset
`default_nettype none

module lock_detector (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire dsp_types_pkg::sample_t phase_err,
    input  wire logic                   rot_valid,
    input  wire logic                   lock_ready,
    output logic                        demod_lock
);

    import dsp_types_pkg::*;
    import loop_cfg_pkg::*;

    logic [data_width-1:0]        err_abs;
    logic [data_width-1:0]        lock_avg;
    logic signed [data_width:0]   ema_diff;
    logic signed [data_width:0]   ema_step;
    logic signed [data_width+1:0] avg_next;

    // |err| fits 12 bits unsigned, including -2048
    assign err_abs = (phase_err < 0) ? data_width'(-phase_err) : data_width'(phase_err);

    // Signed step, floors toward minus infinity
    assign ema_diff = $signed({1'b0, err_abs}) - $signed({1'b0, lock_avg});
    assign ema_step = ema_diff >>> lock_avg_shift;
    assign avg_next = $signed({2'b00, lock_avg}) + (data_width+2)'(ema_step);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_avg <= '1;
        end else if (rot_valid) begin
            if (avg_next < 0)
                lock_avg <= '0;
            else
                lock_avg <= avg_next[data_width-1:0];
        end
    end

    assign demod_lock = (lock_avg < data_width'(lock_threshold)) && lock_ready;

endmodule

`default_nettype wire

/* rtl/costas_top.sv */
// Symbol-rate loop with two-cycle latency; no back-pressure, strobes may be back to back
`default_nettype none

module costas_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire dsp_types_pkg::sample_t sym_i,
    input  wire dsp_types_pkg::sample_t sym_q,
    input  wire logic                   sym_strobe,
    output dsp_types_pkg::sample_t      demod_i,
    output dsp_types_pkg::sample_t      demod_q,
    output logic                        demod_valid,
    output logic                        demod_lock
);

    import dsp_types_pkg::*;
    import loop_cfg_pkg::*;

    sample_t                  cos_val;
    sample_t                  sin_val;
    sample_t                  rot_i;
    sample_t                  rot_q;
    logic                     rot_valid;
    sample_t                  phase_err;
    logic [phase_byte_w-1:0]  phase_byte;
    loop_mode_t               loop_mode;
    logic                     lock_ready;

    // ============================================================
    // Forward path, rotator then slicer
    // ============================================================
    sincos_lut u_lut (
        .phase_byte (phase_byte),
        .cos_val    (cos_val),
        .sin_val    (sin_val)
    );

    phase_rotator u_rot (
        .clk        (clk),
        .rst_n      (rst_n),
        .sym_i      (sym_i),
        .sym_q      (sym_q),
        .sym_strobe (sym_strobe),
        .cos_val    (cos_val),
        .sin_val    (sin_val),
        .rot_i      (rot_i),
        .rot_q      (rot_q),
        .rot_valid  (rot_valid)
    );

    decision_stage u_dec (
        .clk         (clk),
        .rst_n       (rst_n),
        .rot_i       (rot_i),
        .rot_q       (rot_q),
        .rot_valid   (rot_valid),
        .phase_err   (phase_err),
        .demod_i     (demod_i),
        .demod_q     (demod_q),
        .demod_valid (demod_valid)
    );

    // ============================================================
    // Feedback path and lock indication
    // ============================================================
    loop_filter_nco u_nco (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase_err  (phase_err),
        .rot_valid  (rot_valid),
        .loop_mode  (loop_mode),
        .phase_byte (phase_byte)
    );

    loop_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .rot_valid  (rot_valid),
        .loop_mode  (loop_mode),
        .lock_ready (lock_ready)
    );

    lock_detector u_lock (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase_err  (phase_err),
        .rot_valid  (rot_valid),
        .lock_ready (lock_ready),
        .demod_lock (demod_lock)
    );

endmodule

`default_nettype wire

/* tests/costas_props.sv */
// Bound into costas_top; needs the internal rot_valid net, checks only while out of reset
`default_nettype none

module costas_props (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic sym_strobe,
    input  wire logic demod_valid,
    input  wire logic demod_lock,
    input  wire logic rot_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // ============================================================
    // Pipeline timing, two cycles from strobe to valid
    // ============================================================
    a_valid_after_strobe: assert property (
        @(posedge clk) disable iff (!rst_n) $past(sym_strobe, 2) |-> demod_valid
    ) else $error("demod_valid missing two cycles after sym_strobe");

    a_no_spurious_valid: assert property (
        @(posedge clk) disable iff (!rst_n) demod_valid |-> $past(sym_strobe, 2)
    ) else $error("demod_valid without a matching sym_strobe");

    // Lock flag only moves in the cycle after a rot_valid update
    a_lock_after_update: assert property (
        @(posedge clk) disable iff (!rst_n) $changed(demod_lock) |-> $past(rot_valid)
    ) else $error("demod_lock changed without a preceding rot_valid");

endmodule

bind costas_top costas_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .sym_strobe  (sym_strobe),
    .demod_valid (demod_valid),
    .demod_lock  (demod_lock),
    .rot_valid   (rot_valid)
);

`default_nettype wire

/* tests/costas_tb.sv */
// Vector file must hold only diagonal symbols (I equal to Q), so the loop error stays zero
`default_nettype none

module costas_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import dsp_types_pkg::*;
    import loop_cfg_pkg::*;

    // ============================================================
    // Run length and watchdog limit
    // ============================================================
    localparam int num_vec    = 16;
    localparam int num_passes = 20;
    localparam int total_syms = num_vec * num_passes;
    localparam int max_gap    = 3;
    localparam int timeout_ns = total_syms * (max_gap + 3) * 4 + 200;

    logic    clk;
    logic    rst_n;
    sample_t sym_i;
    sample_t sym_q;
    logic    sym_strobe;
    sample_t demod_i;
    sample_t demod_q;
    logic    demod_valid;
    logic    demod_lock;

    // One I, Q, gap triple per vector
    logic [11:0] vec_mem [0:3*num_vec-1];

    // Expected results in symbol order
    sample_t exp_i_q[$];
    sample_t exp_q_q[$];
    logic    exp_lock_q[$];

    int   check_count;
    int   err_count;
    int   rx_count;
    int   idle_checks;
    int   lock_rise_obs;
    int   lock_rise_exp;
    logic strb_d1;
    logic strb_d2;

    costas_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .sym_i       (sym_i),
        .sym_q       (sym_q),
        .sym_strobe  (sym_strobe),
        .demod_i     (demod_i),
        .demod_q     (demod_q),
        .demod_valid (demod_valid),
        .demod_lock  (demod_lock)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Zero NCO phase gives cos 2047, so output is floor(x*2047/2048)
    function automatic sample_t expect_demod(input sample_t x);
        int prod;
        int quo;
        prod = int'(x) * 2047;
        quo  = prod / 2048;
        if (prod < 0 && quo * 2048 != prod)
            quo = quo - 1;
        return sample_t'(quo);
    endfunction

    // Exponential average step with |err| of zero, floored division
    function automatic int next_lock_avg(input int avg);
        int diff;
        int step;
        diff = -avg;
        step = diff / (1 << lock_avg_shift);
        if (step * (1 << lock_avg_shift) != diff)
            step = step - 1;
        if (avg + step < 0)
            return 0;
        return avg + step;
    endfunction

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ============================================================
    // Stimulus and reference model
    // ============================================================
    initial begin
        int      sent;
        int      gap;
        int      lock_avg;
        logic    lock_exp;
        sample_t vi;
        sample_t vq;
        rst_n         = 1'b0;
        sym_strobe    = 1'b0;
        sym_i         = '0;
        sym_q         = '0;
        check_count   = 0;
        err_count     = 0;
        lock_rise_exp = -1;
        sent          = 0;
        lock_avg      = 4095;
        $readmemh("tests/costas_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[3*num_vec-1])) begin
            $display("Vector file tests/costas_vectors.txt is missing or too short");
            $display(">>> FAIL");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            rst_n <= 1'b1;
            // A few idle cycles to observe the reset state
            repeat (4) @(posedge clk);
            for (int p = 0; p < num_passes; p++) begin
                for (int v = 0; v < num_vec; v++) begin
                    vi  = sample_t'(vec_mem[3*v]);
                    vq  = sample_t'(vec_mem[3*v+1]);
                    gap = int'(vec_mem[3*v+2]);
                    sent++;
                    lock_avg = next_lock_avg(lock_avg);
                    lock_exp = (lock_avg < lock_threshold) && (sent >= int'(lock_ready_syms));
                    if (lock_exp && lock_rise_exp < 0)
                        lock_rise_exp = sent;
                    exp_i_q.push_back(expect_demod(vi));
                    exp_q_q.push_back(expect_demod(vq));
                    exp_lock_q.push_back(lock_exp);
                    @(posedge clk);
                    sym_i      <= vi;
                    sym_q      <= vq;
                    sym_strobe <= 1'b1;
                    repeat (gap) begin
                        @(posedge clk);
                        sym_strobe <= 1'b0;
                    end
                end
            end
            @(posedge clk);
            sym_strobe <= 1'b0;
            wait (rx_count == total_syms);
            repeat (3) @(posedge clk);
            $display("test lock: rose at symbol %0d, model %0d", lock_rise_obs, lock_rise_exp);
            if (lock_rise_obs != lock_rise_exp) begin
                err_count++;
                $display("[FAIL] %0t ns: demod_lock rose at symbol %0d expected %0d",
                         $time, lock_rise_obs, lock_rise_exp);
            end
            $display("checks %0d, errors %0d", check_count, err_count);
            if (err_count == 0)
                $display(">>> PASS");
            else
                $display(">>> FAIL");
            $finish;
        end
    end

    // ============================================================
    // Output monitor, sampled on the falling edge
    // ============================================================
    initial begin
        rx_count      = 0;
        idle_checks   = 0;
        lock_rise_obs = -1;
        strb_d1       = 1'b0;
        strb_d2       = 1'b0;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            // Valid must mirror the strobe two cycles earlier
            check_flag(demod_valid, strb_d2, "demod_valid timing");
            strb_d2 = strb_d1;
            strb_d1 = sym_strobe;
            if (demod_valid) begin
                if (rx_count == 0)
                    $display("test reset_idle: %0d idle cycles checked, errors %0d",
                             idle_checks, err_count);
                if (exp_i_q.size() == 0) begin
                    err_count++;
                    $display("Output appeared with no symbol left to compare, at %0t ns", $time);
                end else begin
                    check_sample(demod_i, exp_i_q.pop_front(), "demod_i");
                    check_sample(demod_q, exp_q_q.pop_front(), "demod_q");
                    check_flag(demod_lock, exp_lock_q.pop_front(), "demod_lock");
                end
                rx_count++;
                if (demod_lock && lock_rise_obs < 0)
                    lock_rise_obs = rx_count;
                if (rx_count % num_vec == 0)
                    $display("test pass %0d: %0d symbols checked, errors %0d",
                             rx_count / num_vec, rx_count, err_count);
            end else if (rx_count == 0) begin
                idle_checks++;
                check_sample(demod_i, '0, "demod_i after reset");
                check_sample(demod_q, '0, "demod_q after reset");
                check_flag(demod_lock, 1'b0, "demod_lock after reset");
            end
        end
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        $display("Watchdog expired after %0d ns, the DUT stopped producing outputs", timeout_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/costas_vectors.txt */
// Columns: I, Q (12-bit two's complement hex), idle gap in cycles after the strobe
// Levels: 288 = +648, D78 = -648, 797 = +1943, 869 = -1943
288 288 0
D78 D78 0
797 797 1
869 869 0
288 288 2
797 797 3
D78 D78 0
869 869 1
869 869 0
288 288 0
797 797 2
D78 D78 1
288 288 3
869 869 0
797 797 0
D78 D78 2

/* verilog.f */
rtl/dsp_types_pkg.sv
rtl/loop_cfg_pkg.sv
rtl/sincos_lut.sv
rtl/phase_rotator.sv
rtl/decision_stage.sv
rtl/loop_filter_nco.sv
rtl/loop_sequencer.sv
rtl/lock_detector.sv
rtl/costas_top.sv
tests/costas_props.sv
tests/costas_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module costas_tb \
    -Mdir obj_dir -o costas_sim > build.log 2>&1 &&
./obj_dir/costas_sim > sim.log 2>&1 ;
cat sim.log 2>/dev/null ;
grep -qx '>>> PASS' sim.log && echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
